/* busMaster.sv */
// Bus master that runs one fetch or copy command at a time on the read and write channels
module busMaster import dmaPkg::*; (
    input  logic       ACLK,
    input  logic       ARESETn,
    input  busCmdT     cmd,
    input  logic       cmdValid,
    output logic       cmdReady,
    output logic       cmdDone,
    output addrChT     mAr,
    output logic       mArValid,
    input  logic       mArReady,
    output addrChT     mAw,
    output logic       mAwValid,
    input  logic       mAwReady,
    output wBeatT      mW,
    output logic       mWValid,
    input  logic       mWReady,
    input  rBeatT      mR,
    input  logic       mRValid,
    output logic       mRReady,
    input  respT       mBResp,
    input  logic       mBValid,
    output logic       mBReady,
    output dataT       descBeat,
    output logic       descWrite,
    output logic [2:0] descIndex
);

    busCmdT cur;
    logic   busy;
    logic   arPending;
    logic   awPending;
    logic   respWait;
    lenT    beatCnt;
    logic   isCopy;
    logic   dataPhase;
    logic   lastBeat;
    logic   rFire;

    assign isCopy    = (cur.kind == CmdCopy);
    assign dataPhase = busy && !arPending && !awPending && !respWait;
    assign lastBeat  = (beatCnt == cur.len);
    assign cmdReady  = !busy;

    // ========================================
    // Address phases
    // ========================================
    assign mAr      = '{addr: cur.srcAddr, len: cur.len};
    assign mAw      = '{addr: cur.dstAddr, len: cur.len};
    assign mArValid = arPending;
    assign mAwValid = awPending;

    // ========================================
    // Data phase
    // ========================================
    // A copy forwards each read beat, so a write stall holds the read side
    assign mRReady = dataPhase && (!isCopy || mWReady);
    assign mWValid = dataPhase && isCopy && mRValid;
    assign mW      = '{data: mR.data, strb: FullStrb, last: lastBeat};
    assign rFire   = mRValid && mRReady;

    // Fetch beats go to the descriptor store
    assign descBeat  = mR.data;
    assign descWrite = rFire && !isCopy;
    assign descIndex = beatCnt[2:0];

    // Completion comes from the beat count; an error code in
    // mR.resp or mBResp still ends the command normally
    assign mBReady = respWait;
    assign cmdDone = (descWrite && lastBeat) || (respWait && mBValid);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            busy      <= 1'b0;
            arPending <= 1'b0;
            awPending <= 1'b0;
            respWait  <= 1'b0;
            beatCnt   <= '0;
        end else if (!busy) begin
            if (cmdValid) begin
                busy      <= 1'b1;
                arPending <= 1'b1;
                awPending <= (cmd.kind == CmdCopy);
                respWait  <= 1'b0;
                beatCnt   <= '0;
            end
        end else begin
            if (mArValid && mArReady) arPending <= 1'b0;
            if (mAwValid && mAwReady) awPending <= 1'b0;
            if (rFire) begin
                beatCnt <= beatCnt + 1'b1;
                if (lastBeat) begin
                    if (isCopy) respWait <= 1'b1;
                    else busy <= 1'b0;
                end
            end
            if (respWait && mBValid) begin
                respWait <= 1'b0;
                busy     <= 1'b0;
            end
        end
    end

    // Command latch
    always_ff @(posedge ACLK) begin
        if (cmdValid && cmdReady) cur <= cmd;
    end

endmodule

/* csrSlave.sv */
// Control-port write slave that holds the DMA enable bit set by software and cleared by the engine
module csrSlave import dmaPkg::*; (
    input  logic   ACLK,
    input  logic   ARESETn,
    input  addrChT sAw,
    input  logic   sAwValid,
    output logic   sAwReady,
    input  wBeatT  sW,
    input  logic   sWValid,
    output logic   sWReady,
    output respT   sBResp,
    output logic   sBValid,
    input  logic   sBReady,
    input  logic   chainDone,
    output logic   dmaEn
);

    csrStateT state;
    logic     addrHit;
    respT     resp;
    logic     awFire;
    logic     wFire;
    logic     writeOk;

    assign awFire  = sAwValid && sAwReady;
    assign wFire   = sWValid && sWReady;
    assign writeOk = addrHit && (sW.strb == FullStrb);

    // No new write while a chain is running
    assign sAwReady = (state == Accept) && !dmaEn;
    assign sWReady  = (state == WriteData);
    assign sBValid  = (state == WriteResp);
    assign sBResp   = resp;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state   <= Accept;
            addrHit <= 1'b0;
            resp    <= Okay;
        end else begin
            unique case (state)
                Accept: begin
                    if (awFire) begin
                        addrHit <= (sAw.addr == DmaEnAddr);
                        state   <= WriteData;
                    end
                end
                WriteData: begin
                    if (wFire) begin
                        resp  <= writeOk ? Okay : SlvErr;
                        state <= WriteResp;
                    end
                end
                WriteResp: begin
                    if (sBReady) state <= Accept;
                end
                default: state <= Accept;
            endcase
        end
    end

    // Enable bit, self-cleared at the end of a chain
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            dmaEn <= 1'b0;
        end else if (wFire && writeOk) begin
            dmaEn <= sW.data[0];
        end else if (chainDone) begin
            dmaEn <= 1'b0;
        end
    end

endmodule

/* descStore.sv */
// Descriptor register file written beat by beat during a fetch and read by the sequencer
module descStore import dmaPkg::*; (
    input  logic       ACLK,
    input  logic       ARESETn,
    input  dataT       descBeat,
    input  logic       descWrite,
    input  logic [2:0] descIndex,
    output descT       desc
);

    // Beat order in memory
    // 0 source, 1 destination, 2 length, 3 next descriptor, 4 end of chain
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            desc <= '0;
        end else if (descWrite) begin
            unique case (descIndex)
                3'd0: desc.src  <= descBeat;
                3'd1: desc.dst  <= descBeat;
                // Only beats minus one, low byte
                3'd2: desc.len  <= descBeat[7:0];
                3'd3: desc.next <= descBeat;
                3'd4: desc.eoc  <= descBeat[0];
                default: begin
                    // Beats past the fifth word are ignored
                    desc <= desc;
                end
            endcase
        end
    end

endmodule

/* dmaPkg.sv */
// Shared types and constants of the DMA engine imported by each RTL block and the testbench
package dmaPkg;

    // ========================================
    // Widths
    // ========================================
    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [7:0]  lenT;
    typedef logic [3:0]  strbT;

    // ========================================
    // Addresses and counts
    // ========================================
    localparam addrT DmaEnAddr    = 32'h1002_0100;
    localparam addrT DescBaseAddr = 32'h1002_0200;
    localparam int   DescWords    = 5;
    localparam strbT FullStrb     = 4'hf;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [1:0] {Okay = 2'd0, SlvErr = 2'd2} respT;
    typedef enum logic [1:0] {Accept, WriteData, WriteResp} csrStateT;
    typedef enum logic [1:0] {Idle, Fetch, Copy, Wait} seqStateT;
    // Command kinds carry a prefix so they do not clash with the sequencer states
    typedef enum logic {CmdFetch, CmdCopy} cmdKindT;

    // Channel payloads
    typedef struct packed {addrT addr; lenT len;} addrChT;
    typedef struct packed {dataT data; strbT strb; logic last;} wBeatT;
    typedef struct packed {dataT data; respT resp; logic last;} rBeatT;

    typedef struct packed {
        cmdKindT kind;
        addrT    srcAddr;
        addrT    dstAddr;
        lenT     len;
    } busCmdT;

    typedef struct packed {
        addrT src;
        addrT dst;
        lenT  len;
        addrT next;
        logic eoc;
    } descT;

endpackage

/* dmaSequencer.sv */
// Chain FSM that walks the descriptor list and hands fetch and copy commands to the bus master
module dmaSequencer import dmaPkg::*; (
    input  logic   ACLK,
    input  logic   ARESETn,
    input  logic   dmaEn,
    input  descT   desc,
    output busCmdT cmd,
    output logic   cmdValid,
    input  logic   cmdReady,
    input  logic   cmdDone,
    output logic   chainDone
);

    seqStateT state;
    logic     firstDesc;
    logic     cmdSent;
    addrT     fetchAddr;

    // First descriptor of a chain sits at the fixed base
    assign fetchAddr = firstDesc ? DescBaseAddr : desc.next;

    always_comb begin
        cmd = '0;
        if (state == Copy) begin
            cmd.kind    = CmdCopy;
            cmd.srcAddr = desc.src;
            cmd.dstAddr = desc.dst;
            cmd.len     = desc.len;
        end else begin
            cmd.kind    = CmdFetch;
            cmd.srcAddr = fetchAddr;
            cmd.len     = lenT'(DescWords - 1);
        end
    end

    assign cmdValid  = ((state == Fetch) || (state == Copy)) && !cmdSent;
    assign chainDone = (state == Wait) && desc.eoc;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state     <= Idle;
            firstDesc <= 1'b1;
            cmdSent   <= 1'b0;
        end else begin
            unique case (state)
                Idle: begin
                    if (dmaEn) begin
                        state     <= Fetch;
                        firstDesc <= 1'b1;
                        cmdSent   <= 1'b0;
                    end
                end
                Fetch, Copy: begin
                    if (cmdValid && cmdReady) cmdSent <= 1'b1;
                    if (cmdDone) begin
                        cmdSent <= 1'b0;
                        if (state == Fetch) begin
                            state     <= Copy;
                            firstDesc <= 1'b0;
                        end else begin
                            state <= Wait;
                        end
                    end
                end
                // One cycle to decide between end of chain and next fetch
                Wait: state <= desc.eoc ? Idle : Fetch;
                default: state <= Idle;
            endcase
        end
    end

endmodule

/* dmaTop.sv */
// Top level of the DMA engine joining the control slave, sequencer, descriptor store and bus master
module dmaTop import dmaPkg::*; (
    input  logic   ACLK,
    input  logic   ARESETn,
    // Control slave
    input  addrChT sAw,
    input  logic   sAwValid,
    output logic   sAwReady,
    input  wBeatT  sW,
    input  logic   sWValid,
    output logic   sWReady,
    output respT   sBResp,
    output logic   sBValid,
    input  logic   sBReady,
    // Memory master
    output addrChT mAr,
    output logic   mArValid,
    input  logic   mArReady,
    output addrChT mAw,
    output logic   mAwValid,
    input  logic   mAwReady,
    output wBeatT  mW,
    output logic   mWValid,
    input  logic   mWReady,
    input  rBeatT  mR,
    input  logic   mRValid,
    output logic   mRReady,
    input  respT   mBResp,
    input  logic   mBValid,
    output logic   mBReady
);

    logic       dmaEn;
    logic       chainDone;
    busCmdT     cmd;
    logic       cmdValid;
    logic       cmdReady;
    logic       cmdDone;
    dataT       descBeat;
    logic       descWrite;
    logic [2:0] descIndex;
    descT       desc;

    csrSlave u_csrSlave (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .sAw(sAw), .sAwValid(sAwValid), .sAwReady(sAwReady),
        .sW(sW), .sWValid(sWValid), .sWReady(sWReady),
        .sBResp(sBResp), .sBValid(sBValid), .sBReady(sBReady),
        .chainDone(chainDone), .dmaEn(dmaEn)
    );

    dmaSequencer u_dmaSequencer (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .dmaEn(dmaEn), .desc(desc),
        .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
        .cmdDone(cmdDone), .chainDone(chainDone)
    );

    descStore u_descStore (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .descBeat(descBeat), .descWrite(descWrite), .descIndex(descIndex),
        .desc(desc)
    );

    busMaster u_busMaster (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdDone(cmdDone),
        .mAr(mAr), .mArValid(mArValid), .mArReady(mArReady),
        .mAw(mAw), .mAwValid(mAwValid), .mAwReady(mAwReady),
        .mW(mW), .mWValid(mWValid), .mWReady(mWReady),
        .mR(mR), .mRValid(mRValid), .mRReady(mRReady),
        .mBResp(mBResp), .mBValid(mBValid), .mBReady(mBReady),
        .descBeat(descBeat), .descWrite(descWrite), .descIndex(descIndex)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbDma -f src.f -o simDma \
    && ./obj_dir/simDma > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

/* src.f */
dmaPkg.sv
csrSlave.sv
descStore.sv
dmaSequencer.sv
busMaster.sv
dmaTop.sv
tbClock.sv
tbMemory.sv
tbDma.sv

/* tbClock.sv */
// Testbench clock and reset source, period 8 with reset held low for the first two cycles
module tbClock (
    output logic ACLK,
    output logic ARESETn
);

    initial begin
        ACLK    = 1'b0;
        ARESETn = 1'b0;
    end

    always #4 ACLK = ~ACLK;

    initial begin
        repeat (2) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
    end

endmodule

/* tbDma.sv */
// Testbench top that loads descriptors, starts DMA chains over the control port and checks the copies
module tbDma import dmaPkg::*; ();

    logic   ACLK;
    logic   ARESETn;
    addrChT sAw;
    logic   sAwValid;
    logic   sAwReady;
    wBeatT  sW;
    logic   sWValid;
    logic   sWReady;
    respT   sBResp;
    logic   sBValid;
    logic   sBReady;
    addrChT mAr;
    logic   mArValid;
    logic   mArReady;
    addrChT mAw;
    logic   mAwValid;
    logic   mAwReady;
    wBeatT  mW;
    logic   mWValid;
    logic   mWReady;
    rBeatT  mR;
    logic   mRValid;
    logic   mRReady;
    respT   mBResp;
    logic   mBValid;
    logic   mBReady;

    logic   stallEn;
    logic   loadEn;
    addrT   loadAddr;
    dataT   loadData;
    logic   lockout;
    int     errors = 0;
    int     checks = 0;
    int     resetErrors = 0;
    int     lockErrors = 0;
    int     cycles = 0;

    tbClock u_tbClock (.ACLK(ACLK), .ARESETn(ARESETn));

    tbMemory u_tbMemory (
        .ACLK(ACLK), .ARESETn(ARESETn), .stallEn(stallEn),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .mAr(mAr), .mArValid(mArValid), .mArReady(mArReady),
        .mAw(mAw), .mAwValid(mAwValid), .mAwReady(mAwReady),
        .mW(mW), .mWValid(mWValid), .mWReady(mWReady),
        .mR(mR), .mRValid(mRValid), .mRReady(mRReady),
        .mBResp(mBResp), .mBValid(mBValid), .mBReady(mBReady)
    );

    dmaTop u_dmaTop (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .sAw(sAw), .sAwValid(sAwValid), .sAwReady(sAwReady),
        .sW(sW), .sWValid(sWValid), .sWReady(sWReady),
        .sBResp(sBResp), .sBValid(sBValid), .sBReady(sBReady),
        .mAr(mAr), .mArValid(mArValid), .mArReady(mArReady),
        .mAw(mAw), .mAwValid(mAwValid), .mAwReady(mAwReady),
        .mW(mW), .mWValid(mWValid), .mWReady(mWReady),
        .mR(mR), .mRValid(mRValid), .mRReady(mRReady),
        .mBResp(mBResp), .mBValid(mBValid), .mBReady(mBReady)
    );

    // ========================================
    // Protocol assertions
    // ========================================
    assert property (@(posedge ACLK) !ARESETn |->
        (!mArValid && !mAwValid && !mWValid && !sBValid && sAwReady)) else begin
        resetErrors++;
        $display("Outputs not in their reset state while reset is asserted");
    end

    // No control write may be accepted while a chain runs
    assert property (@(posedge ACLK) lockout |-> !sAwReady) else begin
        lockErrors++;
        $display("sAwReady went high while a chain was still running");
    end

    always @(posedge ACLK) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("Timeout after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Fill value built from every address bit
    function automatic dataT pattern(addrT a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_0f1e;
    endfunction

    task automatic checkValue(string name, dataT exp, dataT act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic loadWord(addrT a, dataT d);
        @(negedge ACLK);
        loadEn   = 1'b1;
        loadAddr = a;
        loadData = d;
    endtask

    task automatic fillRegion(addrT base, int beats);
        for (int i = 0; i < beats; i++) loadWord(base + 4 * i, pattern(base + 4 * i));
        @(negedge ACLK);
        loadEn = 1'b0;
    endtask

    task automatic loadDesc(addrT at, addrT src, addrT dst, lenT len, addrT next, logic eoc);
        loadWord(at, src);
        loadWord(at + 4, dst);
        loadWord(at + 8, dataT'(len));
        loadWord(at + 12, next);
        loadWord(at + 16, dataT'(eoc));
        @(negedge ACLK);
        loadEn = 1'b0;
    endtask

    task automatic checkRegion(string name, addrT src, addrT dst, int beats);
        addrT d;
        for (int i = 0; i < beats; i++) begin
            d = dst + 4 * i;
            checkValue(name, pattern(src + 4 * i), u_tbMemory.mem[d[13:2]]);
        end
    endtask

    task automatic csrWrite(addrT a, dataT d, output respT resp);
        @(negedge ACLK);
        sAw      = '{addr: a, len: '0};
        sAwValid = 1'b1;
        while (!sAwReady) @(negedge ACLK);
        @(negedge ACLK);
        sAwValid = 1'b0;
        sW       = '{data: d, strb: FullStrb, last: 1'b1};
        sWValid  = 1'b1;
        while (!sWReady) @(negedge ACLK);
        @(negedge ACLK);
        sWValid = 1'b0;
        sBReady = 1'b1;
        while (!sBValid) @(negedge ACLK);
        resp = sBResp;
        @(negedge ACLK);
        sBReady = 1'b0;
    endtask

    task automatic runChain(string name, int copies);
        respT resp;
        int   startB;
        int   waited;
        startB = u_tbMemory.bCount;
        csrWrite(DmaEnAddr, 32'd1, resp);
        checkValue({name, " enable resp"}, dataT'(Okay), dataT'(resp));
        lockout = 1'b1;
        while (u_tbMemory.bCount < startB + copies) @(posedge ACLK);
        lockout = 1'b0;
        waited  = 0;
        @(negedge ACLK);
        while (!sAwReady && waited < 8) begin
            @(negedge ACLK);
            waited++;
        end
        assert (sAwReady) else begin
            errors++;
            $display("sAwReady did not return after the chain in %s", name);
        end
    endtask

    initial begin
        respT resp;
        int   rd0;
        int   wr0;
        int   last0;
        int   ar0;
        logic seenAr;
        void'($urandom(32'hf132_5054));
        sAw      = '0;
        sAwValid = 1'b0;
        sW       = '0;
        sWValid  = 1'b0;
        sBReady  = 1'b0;
        stallEn  = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lockout  = 1'b0;

        wait (ARESETn);
        @(negedge ACLK);
        checkValue("reset sAwReady", 32'd1, dataT'(sAwReady));
        checkValue("reset master valids", 32'd0,
                   dataT'({mArValid, mAwValid, mWValid, sBValid}));

        // Rejected write to a wrong address
        csrWrite(DmaEnAddr + 4, 32'd0, resp);
        checkValue("bad address resp", dataT'(SlvErr), dataT'(resp));
        seenAr = 1'b0;
        repeat (50) begin
            @(negedge ACLK);
            if (mArValid) seenAr = 1'b1;
        end
        checkValue("bad address no fetch", 32'd0, dataT'(seenAr));

        // Single descriptor of 9 beats
        fillRegion(32'h1002_1000, 9);
        loadDesc(DescBaseAddr, 32'h1002_1000, 32'h1002_2000, 8'd8, '0, 1'b1);
        rd0   = u_tbMemory.readBeats;
        wr0   = u_tbMemory.writeBeats;
        last0 = u_tbMemory.lastCount;
        runChain("single", 1);
        checkRegion("single data", 32'h1002_1000, 32'h1002_2000, 9);
        checkValue("single reads", 32'd9, dataT'(u_tbMemory.readBeats - rd0 - 5));
        checkValue("single writes", 32'd9, dataT'(u_tbMemory.writeBeats - wr0));
        checkValue("single last count", 32'd1, dataT'(u_tbMemory.lastCount - last0));

        // Two linked descriptors
        fillRegion(32'h1002_1100, 4);
        fillRegion(32'h1002_1200, 6);
        loadDesc(DescBaseAddr, 32'h1002_1100, 32'h1002_2100, 8'd3, 32'h1002_0300, 1'b0);
        loadDesc(32'h1002_0300, 32'h1002_1200, 32'h1002_2200, 8'd5, '0, 1'b1);
        ar0 = u_tbMemory.arCount;
        runChain("chain", 2);
        checkRegion("chain first", 32'h1002_1100, 32'h1002_2100, 4);
        checkRegion("chain second", 32'h1002_1200, 32'h1002_2200, 6);
        checkValue("chain first fetch", DescBaseAddr, u_tbMemory.arLog[ar0 % 64]);
        checkValue("chain second fetch", 32'h1002_0300, u_tbMemory.arLog[(ar0 + 2) % 64]);

        // Random stalls on both data channels
        stallEn = 1'b1;
        fillRegion(32'h1002_1400, 16);
        fillRegion(32'h1002_1500, 12);
        loadDesc(DescBaseAddr, 32'h1002_1400, 32'h1002_2400, 8'd15, 32'h1002_0340, 1'b0);
        loadDesc(32'h1002_0340, 32'h1002_1500, 32'h1002_2500, 8'd11, '0, 1'b1);
        rd0 = u_tbMemory.readBeats;
        wr0 = u_tbMemory.writeBeats;
        runChain("stall", 2);
        checkRegion("stall first", 32'h1002_1400, 32'h1002_2400, 16);
        checkRegion("stall second", 32'h1002_1500, 32'h1002_2500, 12);
        checkValue("stall writes", 32'd28, dataT'(u_tbMemory.writeBeats - wr0));
        checkValue("stall reads vs writes", dataT'(u_tbMemory.writeBeats - wr0),
                   dataT'(u_tbMemory.readBeats - rd0 - 10));

        errors = errors + resetErrors + lockErrors + u_tbMemory.errCount;
        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tbMemory.sv */
// Testbench AXI-style memory that serves read and write bursts, loaded word by word from the testbench
module tbMemory import dmaPkg::*; (
    input  logic   ACLK,
    input  logic   ARESETn,
    input  logic   stallEn,
    input  logic   loadEn,
    input  addrT   loadAddr,
    input  dataT   loadData,
    input  addrChT mAr,
    input  logic   mArValid,
    output logic   mArReady = 1'b0,
    input  addrChT mAw,
    input  logic   mAwValid,
    output logic   mAwReady = 1'b0,
    input  wBeatT  mW,
    input  logic   mWValid,
    output logic   mWReady = 1'b0,
    output rBeatT  mR = '0,
    output logic   mRValid = 1'b0,
    input  logic   mRReady,
    output respT   mBResp = Okay,
    output logic   mBValid = 1'b0,
    input  logic   mBReady
);

    // Word index from address bits 13:2 of a 16 KB window
    dataT   mem [0:4095];
    int     readBeats = 0;
    int     writeBeats = 0;
    int     lastCount = 0;
    int     bCount = 0;
    int     arCount = 0;
    int     errCount = 0;
    addrT   arLog [0:63];

    logic   arHit = 1'b0;
    logic   awHit = 1'b0;
    logic   wHit = 1'b0;
    logic   rHit = 1'b0;
    logic   bHit = 1'b0;
    addrChT arReq;
    addrChT awReq;
    wBeatT  wReq;

    logic   rActive = 1'b0;
    logic   wActive = 1'b0;
    logic   bPending = 1'b0;
    addrT   rAddr = '0;
    addrT   wAddr = '0;
    lenT    rCnt = '0;
    lenT    rLen = '0;
    lenT    wCnt = '0;
    lenT    wLen = '0;

    function automatic logic allowBeat();
        return !stallEn || ($urandom_range(3) != 0);
    endfunction

    // Handshakes and memory writes happen on the rising edge
    always @(posedge ACLK) begin
        arHit <= mArValid && mArReady;
        awHit <= mAwValid && mAwReady;
        wHit  <= mWValid && mWReady;
        rHit  <= mRValid && mRReady;
        bHit  <= mBValid && mBReady;
        arReq <= mAr;
        awReq <= mAw;
        wReq  <= mW;
        if (mWValid && mWReady) mem[wAddr[13:2]] <= mW.data;
        if (loadEn) mem[loadAddr[13:2]] <= loadData;
    end

    // Responses are driven on the falling edge
    always @(negedge ACLK) begin
        if (!ARESETn) begin
            mArReady = 1'b0;
            mAwReady = 1'b0;
            mWReady  = 1'b0;
            mRValid  = 1'b0;
            mBValid  = 1'b0;
            rActive  = 1'b0;
            wActive  = 1'b0;
            bPending = 1'b0;
        end else begin
            // ========================================
            // Read channel
            // ========================================
            if (arHit) begin
                rActive = 1'b1;
                rAddr   = arReq.addr;
                rLen    = arReq.len;
                rCnt    = '0;
                arLog[arCount % 64] = arReq.addr;
                arCount++;
            end
            if (rHit) begin
                readBeats++;
                mRValid = 1'b0;
                if (rCnt == rLen) begin
                    rActive = 1'b0;
                end else begin
                    rCnt  = rCnt + 1'b1;
                    rAddr = rAddr + 32'd4;
                end
            end
            if (rActive && !mRValid && allowBeat()) mRValid = 1'b1;
            mR       = '{data: mem[rAddr[13:2]], resp: Okay, last: (rCnt == rLen)};
            mArReady = !rActive;

            // ========================================
            // Write channel
            // ========================================
            if (awHit) begin
                wActive = 1'b1;
                wAddr   = awReq.addr;
                wLen    = awReq.len;
                wCnt    = '0;
            end
            if (wHit) begin
                writeBeats++;
                if (wReq.last) lastCount++;
                assert (wReq.last == (wCnt == wLen)) else begin
                    errCount++;
                    $display("FAIL mW.last beat %0d expected %0b actual %0b",
                             wCnt, (wCnt == wLen), wReq.last);
                end
                // Every copy beat carries all four byte strobes
                assert (wReq.strb == 4'hf) else begin
                    errCount++;
                    $display("FAIL mW.strb beat %0d expected %h actual %h",
                             wCnt, 4'hf, wReq.strb);
                end
                if (wCnt == wLen) begin
                    wActive  = 1'b0;
                    bPending = 1'b1;
                end else begin
                    wCnt  = wCnt + 1'b1;
                    wAddr = wAddr + 32'd4;
                end
            end
            if (bHit) begin
                bPending = 1'b0;
                bCount++;
            end
            mAwReady = !wActive && !bPending;
            mWReady  = wActive && allowBeat();
            mBValid  = bPending;
        end
    end

endmodule
